/* source/rv_defines.svh */
// ==========================================================================
// core-wide macros: data width, register count, PC reset value and step,
// and bit positions of the RV32 instruction fields
// ==========================================================================

`default_nettype none

`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath
`define XLEN      32          // data word width
`define NUM_REGS  32          // x0..x31

// program counter
`define RESET_PC  0           // first fetch after reset
`define PC_STEP   4           // one word per instruction

// field positions, low bit of each field
`define OPC_LSB   0           // opcode, 7 bits
`define RD_LSB    7           // rd, 5 bits
`define F3_LSB    12          // funct3, 3 bits
`define RS1_LSB   15          // rs1, 5 bits
`define RS2_LSB   20          // rs2, 5 bits
`define F7_LSB    25          // funct7, 7 bits

`endif

`default_nettype wire

/* source/rvPkg.sv */
// ==========================================================================
// rvPkg: word and register index types, opcode, ALU op and branch enums,
// write-back select codes
// ==========================================================================

`include "rv_defines.svh"

`default_nettype none

package rvPkg;

   typedef logic [`XLEN-1:0] wordT;                   // one data word
   typedef logic [$clog2(`NUM_REGS)-1:0] regIdxT;     // 5 bit index

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      opLui    = 7'b0110111,
      opAuipc  = 7'b0010111,
      opJal    = 7'b1101111,
      opJalr   = 7'b1100111,
      opBranch = 7'b1100011,
      opLoad   = 7'b0000011,
      opStore  = 7'b0100011,
      opImm    = 7'b0010011,   // immediate computes
      opReg    = 7'b0110011    // register computes
   } opcodeE;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluSll, aluSlt, aluSltu,
      aluXor, aluSrl, aluSra, aluOr,  aluAnd
   } aluOpE;

   // encoded as funct3 of the branch group
   typedef enum logic [2:0] {
      brEq  = 3'b000,
      brNe  = 3'b001,
      brLt  = 3'b100,
      brGe  = 3'b101,
      brLtu = 3'b110,
      brGeu = 3'b111
   } branchE;

   // write-back source
   localparam logic [1:0] wbAlu  = 2'd0;
   localparam logic [1:0] wbLoad = 2'd1;
   localparam logic [1:0] wbLink = 2'd2;   // pc + 4
   localparam logic [1:0] wbImm  = 2'd3;   // lui

endpackage

`default_nettype wire

/* source/instDecoder.sv */
// ==========================================================================
// instDecoder: field split, immediate assembly, control lines and the
// legality check for the RV32I subset
// ==========================================================================

`timescale 1ns/1ps

`include "rv_defines.svh"

`default_nettype none

module instDecoder (
   input  rvPkg::wordT   instWord,
   output rvPkg::regIdxT rs1,
   output rvPkg::regIdxT rs2,
   output rvPkg::regIdxT rd,
   output rvPkg::wordT   imm,
   output rvPkg::aluOpE  aluOp,
   output logic          aluSrcPc,     // opA from pc
   output logic          aluSrcImm,    // opB from imm
   output logic          regWrite,
   output logic [1:0]    wbSel,
   output logic          isBranch,
   output rvPkg::branchE branchCond,
   output logic          isJal,
   output logic          isJalr,
   output logic          isLoad,
   output logic          isStore,
   output logic          illegal
);
   import rvPkg::*;

   opcodeE     opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       f7Zero;
   logic       f7Alt;                  // 0100000, sub and sra
   wordT       immI;
   wordT       immS;
   wordT       immB;
   wordT       immU;
   wordT       immJ;

   // funct3 to ALU op, alt picks sub or sra
   function automatic aluOpE mapOp(input logic [2:0] f3, input logic alt);
      aluOpE op;
      case (f3)
         3'b000:  op = alt ? aluSub : aluAdd;
         3'b001:  op = aluSll;
         3'b010:  op = aluSlt;
         3'b011:  op = aluSltu;
         3'b100:  op = aluXor;
         3'b101:  op = alt ? aluSra : aluSrl;
         3'b110:  op = aluOr;
         default: op = aluAnd;
      endcase
      return op;
   endfunction

   assign opcode = opcodeE'(instWord[`OPC_LSB +: 7]);
   assign rd     = instWord[`RD_LSB +: 5];
   assign funct3 = instWord[`F3_LSB +: 3];
   assign rs1    = instWord[`RS1_LSB +: 5];
   assign rs2    = instWord[`RS2_LSB +: 5];
   assign funct7 = instWord[`F7_LSB +: 7];
   assign f7Zero = (funct7 == 7'b0000000);
   assign f7Alt  = (funct7 == 7'b0100000);

   // sign extended from bit 31 except U
   assign immI = {{20{instWord[31]}}, instWord[31:20]};
   assign immS = {{20{instWord[31]}}, instWord[31:25], instWord[11:7]};
   assign immB = {{20{instWord[31]}}, instWord[7], instWord[30:25], instWord[11:8], 1'b0};
   assign immU = {instWord[31:12], 12'b0};
   assign immJ = {{12{instWord[31]}}, instWord[19:12], instWord[20], instWord[30:21], 1'b0};

   assign branchCond = branchE'(funct3);   // only looked at when isBranch

   always_comb begin
      imm       = '0;
      aluOp     = aluAdd;                   // address and auipc sums
      aluSrcPc  = 1'b0;
      aluSrcImm = 1'b0;
      regWrite  = 1'b0;
      wbSel     = wbAlu;
      isBranch  = 1'b0;
      isJal     = 1'b0;
      isJalr    = 1'b0;
      isLoad    = 1'b0;
      isStore   = 1'b0;
      illegal   = 1'b0;
      case (opcode)
         opLui: begin
            imm      = immU;
            regWrite = 1'b1;
            wbSel    = wbImm;
         end
         opAuipc: begin
            imm       = immU;
            aluSrcPc  = 1'b1;
            aluSrcImm = 1'b1;
            regWrite  = 1'b1;
         end
         opJal: begin
            imm      = immJ;                 // target from pc adder
            isJal    = 1'b1;
            regWrite = 1'b1;
            wbSel    = wbLink;
         end
         opJalr: begin
            imm       = immI;
            aluSrcImm = 1'b1;                // rs1 + imm in the ALU
            isJalr    = 1'b1;
            regWrite  = 1'b1;
            wbSel     = wbLink;
            illegal   = (funct3 != 3'b000);
         end
         opBranch: begin
            imm      = immB;
            isBranch = 1'b1;
            illegal  = (funct3 == 3'b010) || (funct3 == 3'b011);  // no such branch
         end
         opLoad: begin
            imm       = immI;
            aluSrcImm = 1'b1;
            isLoad    = 1'b1;
            regWrite  = 1'b1;
            wbSel     = wbLoad;
            illegal   = (funct3 != 3'b010);  // lw only
         end
         opStore: begin
            imm       = immS;
            aluSrcImm = 1'b1;
            isStore   = 1'b1;
            illegal   = (funct3 != 3'b010);  // sw only
         end
         opImm: begin
            imm       = immI;
            aluSrcImm = 1'b1;
            regWrite  = 1'b1;
            aluOp     = mapOp(funct3, (funct3 == 3'b101) && f7Alt);
            // shift immediates carry funct7 in imm[11:5]
            illegal   = ((funct3 == 3'b001) && !f7Zero) ||
                        ((funct3 == 3'b101) && !(f7Zero || f7Alt));
         end
         opReg: begin
            regWrite = 1'b1;
            aluOp    = mapOp(funct3, f7Alt);
            illegal  = !(f7Zero || (f7Alt && (funct3 == 3'b000 || funct3 == 3'b101)));
         end
         default: illegal = 1'b1;             // unknown opcode
      endcase
      if (instWord == '0 || instWord == '1) begin
         illegal = 1'b1;
      end
   end

endmodule

`default_nettype wire

/* source/regFile.sv */
// ==========================================================================
// regFile: 32 x 32 registers, two async read ports, one sync write port,
// x0 reads as zero
// ==========================================================================

`timescale 1ns/1ps

`include "rv_defines.svh"

`default_nettype none

module regFile (
   input  logic          clk,
   input  logic          rstN,
   input  rvPkg::regIdxT rs1,
   input  rvPkg::regIdxT rs2,
   output rvPkg::wordT   rdata1,
   output rvPkg::wordT   rdata2,
   input  rvPkg::regIdxT rd,
   input  rvPkg::wordT   wdata,
   input  logic          we
);
   import rvPkg::*;

   wordT regs [`NUM_REGS];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;                     // architectural state starts clean
         end
      end else if (we && rd != '0) begin     // x0 never written
         regs[rd] <= wdata;
      end
   end

   assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
   assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* source/alu.sv */
// ==========================================================================
// alu: add, sub, shifts, signed and unsigned compares, logic ops
// ==========================================================================

`timescale 1ns/1ps

`include "rv_defines.svh"

`default_nettype none

module alu (
   input  rvPkg::wordT  opA,
   input  rvPkg::wordT  opB,
   input  rvPkg::aluOpE aluOp,
   output rvPkg::wordT  result
);
   import rvPkg::*;

   logic [4:0] shamt;                  // low five bits of opB
   logic       ltSigned;
   logic       ltUnsigned;

   assign shamt      = opB[4:0];
   assign ltSigned   = $signed(opA) < $signed(opB);
   assign ltUnsigned = opA < opB;

   always_comb begin
      case (aluOp)
         aluAdd:  result = opA + opB;          // also lw/sw address, auipc, jalr
         aluSub:  result = opA - opB;
         aluSll:  result = opA << shamt;
         aluSlt:  result = {{(`XLEN-1){1'b0}}, ltSigned};
         aluSltu: result = {{(`XLEN-1){1'b0}}, ltUnsigned};
         aluXor:  result = opA ^ opB;
         aluSrl:  result = opA >> shamt;
         aluSra:  result = wordT'($signed(opA) >>> shamt);   // sign fill
         aluOr:   result = opA | opB;
         aluAnd:  result = opA & opB;
         default: result = '0;
      endcase
   end

endmodule

`default_nettype wire

/* source/cpuCore.sv */
// ==========================================================================
// cpuCore: single-cycle RV32I top level with PC, next-PC select, branch
// compare, alignment check, halt and write-back mux
// ==========================================================================

`timescale 1ns/1ps

`include "rv_defines.svh"

`default_nettype none

module cpuCore (
   input  logic        clk,
   input  logic        rstN,
   output rvPkg::wordT instAddr,
   input  rvPkg::wordT instWord,
   output rvPkg::wordT dataAddr,
   output rvPkg::wordT storeData,
   output logic        dataWe,
   input  rvPkg::wordT loadData,
   output logic        halt
);
   import rvPkg::*;

   wordT       pc;
   wordT       nextPc;
   wordT       pcPlus4;
   wordT       pcTarget;               // branch and jal
   regIdxT     rs1;
   regIdxT     rs2;
   regIdxT     rd;
   wordT       imm;
   wordT       rdata1;
   wordT       rdata2;
   wordT       aluA;
   wordT       aluB;
   wordT       aluResult;
   wordT       wbData;
   aluOpE      aluOp;
   branchE     branchCond;
   logic [1:0] wbSel;
   logic       aluSrcPc;
   logic       aluSrcImm;
   logic       regWrite;
   logic       isBranch;
   logic       isJal;
   logic       isJalr;
   logic       isLoad;
   logic       isStore;
   logic       illegal;
   logic       condMet;
   logic       misaligned;
   logic       fault;
   logic       commit;                 // instruction may update state
   logic       rfWe;

   instDecoder uDec (
      .instWord(instWord), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
      .aluOp(aluOp), .aluSrcPc(aluSrcPc), .aluSrcImm(aluSrcImm),
      .regWrite(regWrite), .wbSel(wbSel), .isBranch(isBranch),
      .branchCond(branchCond), .isJal(isJal), .isJalr(isJalr),
      .isLoad(isLoad), .isStore(isStore), .illegal(illegal)
   );

   regFile uRf (
      .clk(clk), .rstN(rstN), .rs1(rs1), .rs2(rs2), .rdata1(rdata1),
      .rdata2(rdata2), .rd(rd), .wdata(wbData), .we(rfWe)
   );

   assign aluA = aluSrcPc ? pc : rdata1;
   assign aluB = aluSrcImm ? imm : rdata2;

   alu uAlu (.opA(aluA), .opB(aluB), .aluOp(aluOp), .result(aluResult));

   // branch condition, bge/bgeu include equality
   always_comb begin
      case (branchCond)
         brEq:    condMet = (rdata1 == rdata2);
         brNe:    condMet = (rdata1 != rdata2);
         brLt:    condMet = $signed(rdata1) < $signed(rdata2);
         brGe:    condMet = $signed(rdata1) >= $signed(rdata2);
         brLtu:   condMet = rdata1 < rdata2;
         brGeu:   condMet = rdata1 >= rdata2;
         default: condMet = 1'b0;
      endcase
   end

   assign pcPlus4  = pc + wordT'(`PC_STEP);
   assign pcTarget = pc + imm;

   always_comb begin
      if (isJal || (isBranch && condMet)) begin
         nextPc = pcTarget;
      end else if (isJalr) begin
         nextPc = {aluResult[`XLEN-1:1], 1'b0};   // bit zero cleared
      end else begin
         nextPc = pcPlus4;
      end
   end

   // fetch address or lw/sw word address off a word boundary
   assign misaligned = (pc[1:0] != 2'b00) ||
                       ((isLoad || isStore) && (aluResult[1:0] != 2'b00));
   assign fault  = illegal || misaligned;
   assign halt   = rstN && fault;        // low while in reset
   assign commit = rstN && !fault;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= wordT'(`RESET_PC);
      end else if (!fault) begin
         pc <= nextPc;                       // holds once halted
      end
   end

   always_comb begin
      case (wbSel)
         wbLoad:  wbData = loadData;
         wbLink:  wbData = pcPlus4;
         wbImm:   wbData = imm;              // lui
         default: wbData = aluResult;
      endcase
   end

   assign rfWe      = commit && regWrite;
   assign dataWe    = commit && isStore;
   assign instAddr  = pc;
   assign dataAddr  = aluResult;
   assign storeData = rdata2;

endmodule

`default_nettype wire

/* dv/tbClock.sv */
// ==========================================================================
// tbClock: 8 ns clock and reset sequencer, four cycles of rstN low at start
// and again on each restart request
// ==========================================================================

`timescale 1ns/1ps

`default_nettype none

module tbClock (
   input  logic restart,            // rising edge starts another reset
   output logic clk,
   output logic rstN
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;        // 8 ns period
   end

   initial begin
      rstN = 1'b0;
      forever begin
         repeat (4) @(posedge clk);
         #1 rstN = 1'b1;            // release just after the edge
         @(posedge restart);
         rstN = 1'b0;               // async assert
      end
   end

endmodule

`default_nettype wire

/* dv/cpuCore_assert.sv */
// ==========================================================================
// cpuCore_assert: halt blocks stores, halt freezes the PC, fetch address
// stays word aligned
// ==========================================================================

`timescale 1ns/1ps

`default_nettype none

module cpuCore_assert (
   input logic        clk,
   input logic        rstN,
   input logic        halt,
   input logic        dataWe,
   input logic [31:0] instAddr
);

   int failCount = 0;               // failed properties so far

   noStoreWhileHalted: assert property (@(posedge clk) disable iff (!rstN)
      halt |-> !dataWe)
      else begin
         $error("dataWe high while halt is high");
         failCount++;
      end

   // PC frozen once halted
   pcHeldWhileHalted: assert property (@(posedge clk) disable iff (!rstN)
      halt |=> $stable(instAddr))
      else begin
         $error("instAddr moved while halt is high");
         failCount++;
      end

   fetchAligned: assert property (@(posedge clk) disable iff (!rstN)
      instAddr[1:0] == 2'b00)
      else begin
         $error("instAddr not a multiple of four");
         failCount++;
      end

endmodule

`default_nettype wire

/* dv/cpuCore_tb.sv */
// ==========================================================================
// cpuCore_tb: instruction and data memory models, directed and random
// programs, ISA reference model, per-cycle compare and watchdog
// ==========================================================================

`timescale 1ns/1ps

`default_nettype none

module cpuCore_tb;

   logic        clk;
   logic        rstN;
   logic        restart;            // asks tbClock for another reset
   logic [31:0] instAddr;
   logic [31:0] instWord;
   logic [31:0] dataAddr;
   logic [31:0] storeData;
   logic        dataWe;
   logic [31:0] loadData;
   logic        halt;

   logic [31:0] imem [256];
   logic [31:0] dmem [256];
   logic [31:0] mDmem [256];        // model view of data memory
   logic [31:0] mRegs [32];
   logic [31:0] mPc;

   logic        storePending;       // write seen in this cycle
   logic [7:0]  storeIdx;
   logic [31:0] storeVal;

   logic [31:0] expPc;
   logic [31:0] expAddr;
   logic [31:0] expData;
   logic [31:0] expRdVal;
   logic [4:0]  expRd;
   logic        expHalt;
   logic        expWe;
   logic        expRdWe;

   int          progLen;
   logic [31:0] haltAt;             // address of the planted halting word
   int          seed;
   int          cycleCount;
   int          cycleLimit;

   tbClock uClk (.restart(restart), .clk(clk), .rstN(rstN));

   cpuCore DUT (
      .clk(clk), .rstN(rstN), .instAddr(instAddr), .instWord(instWord),
      .dataAddr(dataAddr), .storeData(storeData), .dataWe(dataWe),
      .loadData(loadData), .halt(halt)
   );

   bind cpuCore cpuCore_assert uAssert (
      .clk(clk), .rstN(rstN), .halt(halt), .dataWe(dataWe), .instAddr(instAddr)
   );

   // instruction encoders
   function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};   // sw
   endfunction

   function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
   endfunction

   function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

   function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6F};
   endfunction

   // ISA compute results, alt selects sub and sra
   function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
      logic [31:0] r;
      case (f3)
         3'd0:    r = alt ? (x - y) : (x + y);
         3'd1:    r = x << y[4:0];
         3'd2:    r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
         3'd3:    r = (x < y) ? 32'd1 : 32'd0;
         3'd4:    r = x ^ y;
         3'd6:    r = x | y;
         3'd7:    r = x & y;
         default: begin
            if (alt) begin
               r = 32'($signed(x) >>> y[4:0]);
            end else begin
               r = x >> y[4:0];
            end
         end
      endcase
      return r;
   endfunction

   // one instruction on the model state, state itself updated by the caller
   function automatic void refStep(input logic [31:0] pcIn, input logic [31:0] inst,
                                   output logic [31:0] nextPc, output logic haltOut,
                                   output logic weOut, output logic [31:0] stAddr,
                                   output logic [31:0] stData, output logic rdWe,
                                   output logic [4:0] rdIdx, output logic [31:0] rdVal);
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] iI;
      logic [31:0] iS;
      logic [31:0] iB;
      logic [31:0] iU;
      logic [31:0] iJ;
      logic [31:0] addr;
      logic        take;
      logic        bad;
      f3 = inst[14:12];
      f7 = inst[31:25];
      a = mRegs[inst[19:15]];
      b = mRegs[inst[24:20]];
      iI = {{20{inst[31]}}, inst[31:20]};
      iS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      iB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      iU = {inst[31:12], 12'b0};
      iJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      nextPc = pcIn + 32'd4;
      weOut = 1'b0;
      stAddr = '0;
      stData = '0;
      rdWe = 1'b0;
      rdIdx = inst[11:7];
      rdVal = '0;
      take = 1'b0;
      bad = (pcIn[1:0] != 2'b00);    // fetch off a word boundary
      case (inst[6:0])
         7'h37: begin                 // lui
            rdWe = 1'b1;
            rdVal = iU;
         end
         7'h17: begin                 // auipc
            rdWe = 1'b1;
            rdVal = pcIn + iU;
         end
         7'h6F: begin                 // jal
            rdWe = 1'b1;
            rdVal = pcIn + 32'd4;
            nextPc = pcIn + iJ;
         end
         7'h67: begin                 // jalr, bit zero dropped
            rdWe = 1'b1;
            rdVal = pcIn + 32'd4;
            nextPc = (a + iI) & ~32'd1;
            bad = bad || (f3 != 3'd0);
         end
         7'h63: begin
            case (f3)
               3'd0:    take = (a == b);
               3'd1:    take = (a != b);
               3'd4:    take = $signed(a) < $signed(b);
               3'd5:    take = $signed(a) >= $signed(b);   // equal counts
               3'd6:    take = a < b;
               3'd7:    take = a >= b;
               default: bad = 1'b1;
            endcase
            if (take) begin
               nextPc = pcIn + iB;
            end
         end
         7'h03: begin                 // lw
            addr = a + iI;
            bad = bad || (f3 != 3'd2) || (addr[1:0] != 2'b00);
            rdWe = 1'b1;
            rdVal = mDmem[addr[9:2]];
         end
         7'h23: begin                 // sw
            addr = a + iS;
            bad = bad || (f3 != 3'd2) || (addr[1:0] != 2'b00);
            weOut = 1'b1;
            stAddr = addr;
            stData = b;
         end
         7'h13: begin
            bad = bad || ((f3 == 3'd1) && (f7 != 7'h00)) ||
                  ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20));
            rdWe = 1'b1;
            rdVal = aluRef(f3, (f3 == 3'd5) && (f7 == 7'h20), a, iI);
         end
         7'h33: begin
            bad = bad || !((f7 == 7'h00) ||
                           ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
            rdWe = 1'b1;
            rdVal = aluRef(f3, f7 == 7'h20, a, b);
         end
         default: bad = 1'b1;        // unknown opcode
      endcase
      if (inst == 32'h0 || inst == 32'hFFFF_FFFF) begin
         bad = 1'b1;
      end
      if (bad) begin                 // nothing retires
         nextPc = pcIn;
         weOut = 1'b0;
         rdWe = 1'b0;
      end
      if (rdIdx == 5'd0) begin
         rdWe = 1'b0;
      end
      haltOut = bad;
   endfunction

   task automatic check(input string name, input logic [31:0] got,
                        input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got %h, expected %h", name, got, exp);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic put(input logic [31:0] w);
      imem[progLen] = w;
      progLen++;
   endtask

   // branch over one marker increment of x20
   task automatic branchPair(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2);
      put(encB(f3, rs1, rs2, 13'd8));
      put(encI(12'd1, 5'd20, 3'd0, 5'd20, 7'h13));
   endtask

   task automatic buildProgram(input int p);
      logic [31:0] r;
      logic [2:0]  f3;
      logic [11:0] imm12;
      progLen = 0;
      for (int i = 0; i < 256; i++) begin
         imem[i] = (32'(i) << 7) | 32'h7F;    // unknown opcode, tagged by address
      end
      case (p)
         0: begin
            put(encU(20'h80000, 5'd1, 7'h37));              // lui x1
            put(encI(-12'sd5, 5'd0, 3'd0, 5'd2, 7'h13));    // x2 = -5
            put(encI(12'd7, 5'd0, 3'd0, 5'd3, 7'h13));      // x3 = 7
            put(encR(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));       // sub
            put(encR(7'h00, 5'd3, 5'd2, 3'd2, 5'd5));       // slt
            put(encR(7'h00, 5'd3, 5'd2, 3'd3, 5'd6));       // sltu
            put(encR(7'h20, 5'd3, 5'd1, 3'd5, 5'd7));       // sra of negative
            put(encI(12'h401, 5'd2, 3'd5, 5'd8, 7'h13));    // srai
            put(encR(7'h00, 5'd3, 5'd1, 3'd5, 5'd9));       // srl
            put(encR(7'h00, 5'd3, 5'd3, 3'd1, 5'd10));      // sll
            put(encR(7'h00, 5'd3, 5'd2, 3'd4, 5'd11));      // xor
            put(encR(7'h00, 5'd3, 5'd2, 3'd6, 5'd12));      // or
            put(encI(12'h0F0, 5'd2, 3'd7, 5'd13, 7'h13));   // andi
            put(encI(12'h555, 5'd2, 3'd4, 5'd14, 7'h13));   // xori
            put(encI(-12'sd4, 5'd2, 3'd2, 5'd15, 7'h13));   // slti
            put(encI(-12'sd1, 5'd3, 3'd3, 5'd16, 7'h13));   // sltiu
            put(encI(12'd3, 5'd3, 3'd1, 5'd17, 7'h13));     // slli
            put(encI(12'd2, 5'd1, 3'd5, 5'd18, 7'h13));     // srli
            put(encU(20'h12345, 5'd19, 7'h17));             // auipc
            // round trip through memory
            put(encS(12'h080, 5'd4, 5'd0));
            put(encI(12'h080, 5'd0, 3'd2, 5'd25, 7'h03));
            put(encS(12'h084, 5'd25, 5'd0));
            put(encI(12'h040, 5'd0, 3'd2, 5'd26, 7'h03));   // fill pattern word
            put(encS(12'h088, 5'd26, 5'd0));
            // each branch taken, then not taken
            branchPair(3'd0, 5'd3, 5'd3);
            branchPair(3'd0, 5'd2, 5'd3);
            branchPair(3'd1, 5'd2, 5'd3);
            branchPair(3'd1, 5'd3, 5'd3);
            branchPair(3'd4, 5'd2, 5'd3);
            branchPair(3'd4, 5'd3, 5'd2);
            branchPair(3'd5, 5'd3, 5'd3);                   // bge on equal
            branchPair(3'd5, 5'd2, 5'd3);
            branchPair(3'd6, 5'd3, 5'd2);
            branchPair(3'd6, 5'd2, 5'd3);
            branchPair(3'd7, 5'd2, 5'd3);
            branchPair(3'd7, 5'd3, 5'd2);
            put(encJ(21'd8, 5'd21));                        // jal over marker
            put(encI(12'd1, 5'd20, 3'd0, 5'd20, 7'h13));
            put(encU(20'h0, 5'd22, 7'h17));
            put(encI(12'd13, 5'd22, 3'd0, 5'd23, 7'h67));   // odd target
            put(encI(12'd1, 5'd20, 3'd0, 5'd20, 7'h13));
            // random computes into x24..x31
            for (int k = 0; k < 40; k++) begin
               r = $random(seed);
               f3 = r[15:13];
               if (r[16]) begin
                  put(encR((r[17] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                           r[12:8], r[7:3], f3, 5'd24 + 5'(r[2:0])));
               end else begin
                  imm12 = r[28:17];
                  if (f3 == 3'd1) begin
                     imm12[11:5] = 7'h00;
                  end
                  if (f3 == 3'd5) begin
                     imm12[11:5] = r[29] ? 7'h20 : 7'h00;
                  end
                  put(encI(imm12, r[7:3], f3, 5'd24 + 5'(r[2:0]), 7'h13));
               end
            end
            for (int i = 1; i < 32; i++) begin
               put(encS(12'(32'h200 + 4 * i), 5'(i), 5'd0));   // dump x1..x31
            end
            haltAt = 32'(progLen * 4);
            put(32'h0BAD_007F);
         end
         1: begin
            put(encI(12'd3, 5'd0, 3'd0, 5'd1, 7'h13));
            put(encS(12'h300, 5'd1, 5'd0));
            haltAt = 32'd8;
            put(encR(7'h01, 5'd1, 5'd1, 3'd0, 5'd2));       // mul, dropped
         end
         2: begin
            put(encI(12'd9, 5'd0, 3'd0, 5'd1, 7'h13));
            haltAt = 32'd4;
            put(32'h0);
         end
         3: begin
            put(encI(12'h302, 5'd0, 3'd0, 5'd1, 7'h13));
            haltAt = 32'd4;
            put(encS(12'd0, 5'd1, 5'd1));                   // sw to 0x302
         end
         default: begin
            put(encI(12'h301, 5'd0, 3'd0, 5'd1, 7'h13));
            haltAt = 32'd4;
            put(encI(12'd0, 5'd1, 3'd2, 5'd2, 7'h03));      // lw from 0x301
         end
      endcase
   endtask

   task automatic resetModel();
      mPc = 32'd0;
      for (int i = 0; i < 32; i++) begin
         mRegs[i] = '0;
      end
   endtask

   // memory models, store lands on the edge, reads refreshed after it
   always @(posedge clk) begin
      if (storePending) begin
         dmem[storeIdx] = storeVal;
      end
      #1;
      instWord = imem[instAddr[9:2]];
      #1;                            // dataAddr follows the new word
      loadData = dmem[dataAddr[9:2]];
   end

   always @(negedge clk) begin
      storePending = dataWe;
      storeIdx = dataAddr[9:2];
      storeVal = storeData;
   end

   // compare against the model mid cycle
   always @(negedge clk) begin
      if (rstN) begin
         refStep(mPc, imem[mPc[9:2]], expPc, expHalt, expWe, expAddr, expData,
                 expRdWe, expRd, expRdVal);
         check("instAddr", instAddr, mPc);
         check("halt", 32'(halt), 32'(expHalt));
         check("dataWe", 32'(dataWe), 32'(expWe));
         if (expWe) begin
            check("dataAddr", dataAddr, expAddr);
            check("storeData", storeData, expData);
         end
         if (!expHalt) begin
            if (expRdWe) begin
               mRegs[expRd] = expRdVal;
            end
            if (expWe) begin
               mDmem[expAddr[9:2]] = expData;
            end
            mPc = expPc;
         end
      end
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount > cycleLimit) begin
         $display("Timeout: no halt after %0d cycles", cycleLimit);
         $display("Simulation failed");
         $fatal(1, "watchdog expired");
      end
   end

   // any failed property of the bound checker
   always @(DUT.uAssert.failCount) begin
      if (DUT.uAssert.failCount != 0) begin
         $display("A bound assertion on the DUT failed");
         $display("Simulation failed");
         $fatal(1, "assertion failed");
      end
   end

   initial begin
      seed = 32'h0893_1409;
      restart = 1'b0;
      instWord = '0;
      loadData = '0;
      storePending = 1'b0;
      storeIdx = '0;
      storeVal = '0;
      cycleCount = 0;
      cycleLimit = 1000;
      for (int i = 0; i < 256; i++) begin
         dmem[i] = 32'hC0DE_0000 ^ (32'(i) << 2);
         mDmem[i] = dmem[i];
      end
      // phase 0 main program, then one phase per halt cause
      for (int p = 0; p < 5; p++) begin
         if (p != 0) begin
            @(posedge clk);
            #1 restart = 1'b1;
         end
         buildProgram(p);
         resetModel();
         cycleCount = 0;
         cycleLimit = 4 + 2 * progLen + 20;
         if (p != 0) begin
            @(posedge clk);
            #1 restart = 1'b0;
         end
         @(posedge rstN);
         do begin
            @(negedge clk);
         end while (!halt);
         repeat (3) @(negedge clk);            // halt must hold
         check("instAddr", instAddr, haltAt);
         for (int i = 0; i < 256; i++) begin
            check($sformatf("dmem[%0d]", i), dmem[i], mDmem[i]);
         end
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

/* Bender.yml */
package:
  name: cpuCore

sources:
  - include_dirs:
      - source
    files:
      - source/rvPkg.sv
      - source/instDecoder.sv
      - source/regFile.sv
      - source/alu.sv
      - source/cpuCore.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tbClock.sv
      - dv/cpuCore_assert.sv
      - dv/cpuCore_tb.sv

/* all.f */
+incdir+source
source/rvPkg.sv
source/instDecoder.sv
source/regFile.sv
source/alu.sv
source/cpuCore.sv
dv/tbClock.sv
dv/cpuCore_assert.sv
dv/cpuCore_tb.sv
